//--- Makefile
# Verilator build for the convolution output stage

VERILATOR ?= verilator
TOP       ?= tb_conv_out
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- add_bias.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module add_bias (
    input  wire logic           clk,
    input  wire logic           reset,

    psum_row_if.adder           in,

    output logic                out_valid,
    output conv_out_pkg::row_t  out_row
);
    import conv_out_pkg::*;

    // lanes per output channel in either mode
    localparam int LANES  = `PIXEL_PAR * `COLUMN_NUM;
    localparam int W88    = `LANE_W_88 * LANES;     // used part of the bus in mode 0
    localparam int HALF   = `ROW_W / 2;             // channel B starts here in mode 1

    ////////////////////////////////////////////////////////////
    // bias split and sign extension
    ////////////////////////////////////////////////////////////

    bias_t   bias_a;
    bias_t   bias_b;
    lane88_t bias_a88;
    lane18_t bias_a18;
    lane18_t bias_b18;

    assign bias_a = in.bias_set[`BIAS_W-1:0];
    assign bias_b = in.bias_set[2*`BIAS_W-1:`BIAS_W];

    assign bias_a88 = {{(`LANE_W_88-`BIAS_W){bias_a[`BIAS_W-1]}}, bias_a};
    assign bias_a18 = {{(`LANE_W_18-`BIAS_W){bias_a[`BIAS_W-1]}}, bias_a};
    assign bias_b18 = {{(`LANE_W_18-`BIAS_W){bias_b[`BIAS_W-1]}}, bias_b};

    ////////////////////////////////////////////////////////////
    // per lane sums for both precisions
    ////////////////////////////////////////////////////////////

    row_t sum_88;
    row_t sum_18;
    row_t sum_sel;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane88_t lane_88;
        lane18_t lane_a;
        lane18_t lane_b;

        // sums wrap at the lane width
        assign lane_88 = in.row[i*`LANE_W_88 +: `LANE_W_88] + bias_a88;
        assign lane_a  = in.row[i*`LANE_W_18 +: `LANE_W_18] + bias_a18;
        assign lane_b  = in.row[HALF + i*`LANE_W_18 +: `LANE_W_18] + bias_b18;

        assign sum_88[i*`LANE_W_88 +: `LANE_W_88]        = lane_88;
        assign sum_18[i*`LANE_W_18 +: `LANE_W_18]        = lane_a;   // channel A
        assign sum_18[HALF + i*`LANE_W_18 +: `LANE_W_18] = lane_b;   // channel B
    end

    assign sum_88[`ROW_W-1:W88] = '0;     // unused top of the bus in mode 0

    assign sum_sel = (in.mode == prec_18) ? sum_18 : sum_88;

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_row   <= '0;
        end else begin
            out_valid <= in.en;
            if (in.en) begin
                out_row <= sum_sel;    // holds until the next row
            end
        end
    end

    // mode comes out of the fetch stage registers
    a_mode_known : assert property (
        @(posedge clk) disable iff (reset)
        in.en |-> !$isunknown(in.mode)
    ) else $error("add_bias: mode unknown on a row strobe");

endmodule

`default_nettype wire

//--- bias_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module bias_fetch (
    input  wire logic                     clk,
    input  wire logic                     reset,

    // bias tile write port
    input  wire logic                     bias_wr,
    input  wire conv_out_pkg::set_idx_t   bias_wr_idx,
    input  wire conv_out_pkg::bias_set_t  bias_wr_data,

    // rows from the array
    input  wire logic                     row_valid,
    input  wire conv_out_pkg::prec_mode_t row_mode,
    input  wire conv_out_pkg::set_idx_t   row_idx,
    input  wire conv_out_pkg::row_t       row_in,

    psum_row_if.fetch                     out
);
    import conv_out_pkg::*;

    ////////////////////////////////////////////////////////////
    // bias tile
    ////////////////////////////////////////////////////////////

    bias_set_t bias_tile [`BIAS_SETS];     // one entry per channel set

    always_ff @(posedge clk) begin
        if (bias_wr) begin
            bias_tile[bias_wr_idx] <= bias_wr_data;
        end
    end

    // registered read, a write to the same index lands after the read
    always_ff @(posedge clk) begin
        if (row_valid) begin
            out.bias_set <= bias_tile[row_idx];
        end
    end

    ////////////////////////////////////////////////////////////
    // row alignment
    ////////////////////////////////////////////////////////////

    // row and mode wait one cycle for the tile read
    always_ff @(posedge clk) begin
        if (row_valid) begin
            out.row  <= row_in;
            out.mode <= row_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.en <= 1'b0;
        end else begin
            out.en <= row_valid;    // strobe travels with the read data
        end
    end

    // tile depth may not be a power of two with other geometries
    a_idx_in_range : assert property (
        @(posedge clk) disable iff (reset)
        (bias_wr |-> int'(bias_wr_idx) < `BIAS_SETS) and
        (row_valid |-> int'(row_idx) < `BIAS_SETS)
    ) else $error("bias_fetch: bias set index out of range");

endmodule

`default_nettype wire

//--- conv_out_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module conv_out_checker (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     bias_wr,
    input  wire conv_out_pkg::set_idx_t   bias_wr_idx,
    input  wire conv_out_pkg::bias_set_t  bias_wr_data,
    input  wire logic                     row_valid,
    input  wire conv_out_pkg::prec_mode_t row_mode,
    input  wire conv_out_pkg::set_idx_t   row_idx,
    input  wire conv_out_pkg::row_t       row_in,
    input  wire logic                     out_valid,
    input  wire conv_out_pkg::row_t       out_row,
    input  wire logic                     spot_en,       // hand-written lane 0 value
    input  wire conv_out_pkg::lane88_t    spot_value,
    input  wire logic                     end_of_test,
    output int                            mismatch_count,
    output int                            fault_count
);
    import conv_out_pkg::*;

    localparam int LANES = `PIXEL_PAR * `COLUMN_NUM;
    localparam int HALF  = `ROW_W / 2;

    typedef struct {
        row_t       row;
        prec_mode_t mode;
        logic       has_spot;
        lane88_t    spot;
    } pred_t;

    bias_set_t shadow_tile [`BIAS_SETS];
    pred_t     pred_q [$];
    row_t      last_row;          // what out_row must hold between rows
    logic [1:0] valid_hist;       // row_valid from one and two edges back
    logic      drained_done;

    ////////////////////////////////////////////////////////////
    // reference model of the lane rule
    ////////////////////////////////////////////////////////////

    function automatic row_t predict(input prec_mode_t mode, input bias_set_t b, input row_t r);
        row_t p;
        int   lane_sum;
        p = '0;                   // mode 0 leaves the top 64 bits clear
        for (int i = 0; i < LANES; i++) begin
            if (mode == prec_88) begin
                lane_sum = int'(r[i*`LANE_W_88 +: `LANE_W_88]) + int'($signed(b[7:0]));
                p[i*`LANE_W_88 +: `LANE_W_88] = lane_sum[`LANE_W_88-1:0];
            end else begin
                lane_sum = int'(r[i*`LANE_W_18 +: `LANE_W_18]) + int'($signed(b[7:0]));
                p[i*`LANE_W_18 +: `LANE_W_18] = lane_sum[`LANE_W_18-1:0];
                lane_sum = int'(r[HALF + i*`LANE_W_18 +: `LANE_W_18]) + int'($signed(b[15:8]));
                p[HALF + i*`LANE_W_18 +: `LANE_W_18] = lane_sum[`LANE_W_18-1:0];
            end
        end
        return p;
    endfunction

    always @(posedge clk) begin
        pred_t p;
        pred_t n;
        if (reset) begin
            valid_hist     = 2'b00;
            last_row       = '0;
            mismatch_count = 0;
            fault_count    = 0;
            drained_done   = 1'b0;
            pred_q.delete();
        end else begin
            // output side, the row accepted two edges ago
            if (out_valid !== valid_hist[1]) begin
                $display("MISMATCH at %0t: out_valid expected %b got %b",
                         $time, valid_hist[1], out_valid);
                mismatch_count++;
            end
            if (out_valid === 1'b1) begin
                if (pred_q.size() == 0) begin
                    $display("at %0t: out_valid went high with no row waiting for output", $time);
                    fault_count++;
                end else begin
                    p = pred_q.pop_front();
                    if (out_row !== p.row) begin
                        $display("MISMATCH at %0t: out_row expected %h got %h",
                                 $time, p.row, out_row);
                        mismatch_count++;
                    end
                    if (p.has_spot && p.mode == prec_88 && out_row[23:0] !== p.spot) begin
                        $display("MISMATCH at %0t: out_row lane 0 expected %h got %h",
                                 $time, p.spot, out_row[23:0]);
                        mismatch_count++;
                    end
                    if (p.has_spot && p.mode == prec_18 && out_row[15:0] !== p.spot[15:0]) begin
                        $display("MISMATCH at %0t: out_row lane 0 expected %h got %h",
                                 $time, p.spot[15:0], out_row[15:0]);
                        mismatch_count++;
                    end
                    last_row = p.row;
                end
            end else if (out_row !== last_row) begin
                $display("MISMATCH at %0t: out_row expected %h got %h", $time, last_row, out_row);
                mismatch_count++;
            end

            // input side, read the tile before this edge's write lands
            if (row_valid) begin
                n.row      = predict(row_mode, shadow_tile[row_idx], row_in);
                n.mode     = row_mode;
                n.has_spot = spot_en;
                n.spot     = spot_value;
                pred_q.push_back(n);
            end
            if (bias_wr) begin
                shadow_tile[bias_wr_idx] = bias_wr_data;
            end
            valid_hist = {valid_hist[0], row_valid};

            if (end_of_test && !drained_done) begin
                drained_done = 1'b1;
                if (pred_q.size() != 0) begin
                    $display("%0d rows were accepted but never came out", pred_q.size());
                    fault_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- conv_out_pkg.sv
`default_nettype none

`include "conv_out_settings.svh"

package conv_out_pkg;

    // one pixel lane in each precision
    typedef logic [`LANE_W_88-1:0] lane88_t;   // 16 bit value + headroom
    typedef logic [`LANE_W_18-1:0] lane18_t;   // 8 bit value + headroom

    typedef logic [`BIAS_W-1:0] bias_t;

    // low byte is channel A, high byte is channel B
    // mode 0 only looks at channel A
    typedef logic [2*`BIAS_W-1:0] bias_set_t;

    // full row bus out of the array columns
    typedef logic [`ROW_W-1:0] row_t;

    // address into the bias tile
    typedef logic [$clog2(`BIAS_SETS)-1:0] set_idx_t;

    // row precision, picked per row
    typedef enum logic {
        prec_88 = 1'b0,     // one channel, 24 bit lanes
        prec_18 = 1'b1      // two channels, 16 bit lanes
    } prec_mode_t;

endpackage

`default_nettype wire

//--- conv_out_settings.svh
`ifndef CONV_OUT_SETTINGS_SVH
`define CONV_OUT_SETTINGS_SVH

////////////////////////////////////////////////////////////
// array geometry
////////////////////////////////////////////////////////////
`define COLUMN_NUM  4                      // array columns, shrunk for simulation
`define ROW_NUM     16                     // tile rows
`define SA_ROW_NUM  4                      // channel rows in the conv core
`define PIXEL_PAR   2                      // pixels per processing element

////////////////////////////////////////////////////////////
// lane and bias widths
////////////////////////////////////////////////////////////
`define HEADROOM    8
`define LANE_W_88   (16 + `HEADROOM)       // 8b x 8b products, 24 bits
`define LANE_W_18   (8 + `HEADROOM)        // 1b x 8b products, 16 bits
`define BIAS_W      8

// one bias set per channel row and tile row
`define BIAS_SETS   (`SA_ROW_NUM * `ROW_NUM)

// mode-1 layout is the wider one, so it sizes the bus
`define ROW_W       (`LANE_W_18 * `PIXEL_PAR * 2 * `COLUMN_NUM)

`endif

//--- conv_out_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_out_top (
    input  wire logic                     clk,
    input  wire logic                     reset,

    // bias load
    input  wire logic                     bias_wr,
    input  wire conv_out_pkg::set_idx_t   bias_wr_idx,
    input  wire conv_out_pkg::bias_set_t  bias_wr_data,

    // partial sum rows in
    input  wire logic                     row_valid,
    input  wire conv_out_pkg::prec_mode_t row_mode,
    input  wire conv_out_pkg::set_idx_t   row_idx,
    input  wire conv_out_pkg::row_t       row_in,

    // biased rows out, two cycles behind row_valid
    output logic                          out_valid,
    output conv_out_pkg::row_t            out_row
);

    ////////////////////////////////////////////////////////////
    // fetch stage to adder
    ////////////////////////////////////////////////////////////

    psum_row_if row_bus ();

    // stage 1: bias tile read, row delayed to match
    bias_fetch bias_fetch_i (
        .clk          (clk),
        .reset        (reset),
        .bias_wr      (bias_wr),
        .bias_wr_idx  (bias_wr_idx),
        .bias_wr_data (bias_wr_data),
        .row_valid    (row_valid),
        .row_mode     (row_mode),
        .row_idx      (row_idx),
        .row_in       (row_in),
        .out          (row_bus.fetch)
    );

    // stage 2: lane sums and output register
    add_bias add_bias_i (
        .clk       (clk),
        .reset     (reset),
        .in        (row_bus.adder),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

endmodule

`default_nettype wire

//--- project.f
+incdir+.
conv_out_pkg.sv
psum_row_if.sv
bias_fetch.sv
add_bias.sv
conv_out_top.sv
conv_out_checker.sv
tb_conv_out.sv

//--- psum_row_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

// row plus its bias set, fetch stage to adder
interface psum_row_if;
    import conv_out_pkg::*;

    logic       en;          // one cycle per row
    prec_mode_t mode;
    row_t       row;
    bias_set_t  bias_set;    // already aligned with row

    modport fetch (
        output en,
        output mode,
        output row,
        output bias_set
    );

    modport adder (
        input en,
        input mode,
        input row,
        input bias_set
    );

endinterface

`default_nettype wire

//--- tb_conv_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_out_settings.svh"

module tb_conv_out;
    import conv_out_pkg::*;

    typedef enum logic [1:0] {op_idle, op_write, op_row, op_write_row} op_t;

    typedef struct {
        op_t        op;
        prec_mode_t mode;
        set_idx_t   idx;
        bias_set_t  bias;
        int         pattern;          // 0 random, 1 and 2 hand-written
        logic       has_spot;
        lane88_t    check_expected;   // lane 0 of the output row
    } stim_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       bias_wr;
    set_idx_t   bias_wr_idx;
    bias_set_t  bias_wr_data;
    logic       row_valid;
    prec_mode_t row_mode;
    set_idx_t   row_idx;
    row_t       row_in;
    logic       out_valid;
    row_t       out_row;
    logic       spot_en;
    lane88_t    spot_value;
    logic       end_of_test;
    logic       table_ready = 1'b0;
    int         mismatch_count;
    int         fault_count;
    stim_t      stim_q [$];

    always #50 clk = ~clk;

    conv_out_top conv_out_top_i (.*);

    conv_out_checker conv_out_checker_i (.*);

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic add_entry(input op_t op, input prec_mode_t mode, input set_idx_t idx,
                             input bias_set_t bias, input int pattern,
                             input logic has_spot, input lane88_t check_expected);
        stim_t e;
        e = '{op, mode, idx, bias, pattern, has_spot, check_expected};
        stim_q.push_back(e);
    endtask

    function automatic row_t make_row(input int pattern);
        row_t r;
        r = '0;
        if (pattern == 1) begin
            r = '1;                                     // top 64 bits must be ignored
            for (int i = 0; i < 8; i++) begin
                r[i*24 +: 24] = 24'h001000 + 24'(i) * 24'h000111;
            end
            r[7*24 +: 24] = 24'hffffff;                 // wraps with a positive bias
        end else if (pattern == 2) begin
            for (int i = 0; i < 8; i++) begin
                r[i*16 +: 16]       = 16'hfff8 + 16'(i);
                r[128 + i*16 +: 16] = 16'h0040 * 16'(i);
            end
        end else begin
            for (int w = 0; w < `ROW_W / 32; w++) begin
                r[w*32 +: 32] = $urandom();
            end
        end
        return r;
    endfunction

    task automatic apply_entry(input stim_t e);
        bias_wr      = (e.op == op_write || e.op == op_write_row);
        bias_wr_idx  = e.idx;
        bias_wr_data = e.bias;
        row_valid    = (e.op == op_row || e.op == op_write_row);
        row_mode     = e.mode;
        row_idx      = e.idx;
        row_in       = row_valid ? make_row(e.pattern) : '0;
        spot_en      = row_valid && e.has_spot;
        spot_value   = e.check_expected;
    endtask

    task automatic fill_table();
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_write,     prec_88, 6'd3,  16'h20f6, 0, 1'b0, 24'h0);   // A = -10
        add_entry(op_write,     prec_88, 6'd5,  16'h850c, 0, 1'b0, 24'h0);   // B = -123
        add_entry(op_write,     prec_88, 6'd12, 16'h7f80, 0, 1'b0, 24'h0);
        add_entry(op_write,     prec_88, 6'd63, 16'h01ff, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_row,       prec_88, 6'd3,  16'h0000, 1, 1'b1, 24'h000ff6);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_row,       prec_88, 6'd5,  16'h0000, 1, 1'b1, 24'h00100c);
        add_entry(op_row,       prec_18, 6'd5,  16'h0000, 2, 1'b1, 24'h000004);
        add_entry(op_row,       prec_18, 6'd3,  16'h0000, 2, 1'b1, 24'h00ffee);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        // back to back, mixed modes
        add_entry(op_row,       prec_88, 6'd12, 16'h0000, 1, 1'b1, 24'h000f80);
        add_entry(op_row,       prec_18, 6'd63, 16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_row,       prec_88, 6'd63, 16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_row,       prec_18, 6'd12, 16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_row,       prec_88, 6'd5,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        // rewrite set 3 while a row reads it
        add_entry(op_write_row, prec_18, 6'd3,  16'h1122, 2, 1'b1, 24'h00ffee);
        add_entry(op_row,       prec_18, 6'd3,  16'h0000, 2, 1'b1, 24'h00001a);
        add_entry(op_row,       prec_88, 6'd3,  16'h0000, 1, 1'b1, 24'h001022);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
        add_entry(op_idle,      prec_88, 6'd0,  16'h0000, 0, 1'b0, 24'h0);
    endtask

    initial begin
        stim_t idle;
        void'($urandom(32'hdaa7));
        idle = '{op_idle, prec_88, 6'd0, 16'h0000, 0, 1'b0, 24'h0};
        reset       = 1'b1;
        end_of_test = 1'b0;
        apply_entry(idle);
        fill_table();
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        foreach (stim_q[k]) begin
            @(posedge clk);
            #1;
            apply_entry(stim_q[k]);
        end
        @(posedge clk);
        #1 apply_entry(idle);
        repeat (3) @(posedge clk);
        #1 end_of_test = 1'b1;          // checker looks for rows still in flight
        @(posedge clk);
        #1;

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #((stim_q.size() + 20) * 100);
        $display("watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
